/* tb.f */
logic/rabin_pkg.sv
logic/src_fetch.sv
logic/rabin_fold.sv
logic/chunk_length.sv
logic/chunk_decide.sv
logic/rabin_chunker.sv
test/rabin_chunker_properties.sv
test/tb_rabin_chunker.sv

/* run.sh */
#!/bin/sh
# build and run the rabin_chunker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rabin_chunker \
   -f tb.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
   exit 0
else
   exit 1
fi

/* test/tb_rabin_chunker.sv */
//**************************************************
// testbench for rabin_chunker: FIFO models,
// reference chunker and descriptor compare
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_rabin_chunker
   import rabin_pkg::*;
();

   localparam int MAX_WORDS = 128;
   localparam int TIMEOUT   = 5000;

   logic              wb_clk_i;
   logic              rst_n;
   logic              m_enable;
   logic [23:0]       dc;
   logic [WORD_W-1:0] m_src;
   logic              m_src_last;
   logic              m_src_empty;
   logic              m_dst_full;
   logic              m_src_getn;
   logic              m_dst_putn;
   logic [WORD_W-1:0] m_dst;
   logic              m_dst_last;
   logic              m_endn;
   logic [7:0]        m_cap;

   // source stream image
   logic [WORD_W-1:0] src_data [MAX_WORDS];
   int                src_len;
   int                src_idx;

   // expected descriptors, oldest first
   logic [63:0]       exp_q [$];

   string             cur_test;
   int                errors;
   int                checks;
   int                got_cnt;
   int                endn_cnt;
   logic              got_last;
   logic              gap_en;
   logic              full_en;
   logic [31:0]       data_rng;
   logic [31:0]       src_rng;
   logic [31:0]       dst_rng;

   rabin_chunker uut (
      .wb_clk_i    (wb_clk_i),
      .rst_n       (rst_n),
      .m_enable    (m_enable),
      .dc          (dc),
      .m_src       (m_src),
      .m_src_last  (m_src_last),
      .m_src_empty (m_src_empty),
      .m_dst_full  (m_dst_full),
      .m_src_getn  (m_src_getn),
      .m_dst_putn  (m_dst_putn),
      .m_dst       (m_dst),
      .m_dst_last  (m_dst_last),
      .m_endn      (m_endn),
      .m_cap       (m_cap)
   );

   // 100 ns clock
   always #50 wb_clk_i = ~wb_clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // long division of {fp, d} by x^32 + RABIN_POLY
   function automatic logic [31:0] ref_fold(input logic [31:0] fp, input logic [63:0] d);
      logic [95:0] v;
      v = {fp, d};
      for (int i = 95; i >= 32; i--) begin
         if (v[i]) begin
            v[i-:33] = v[i-:33] ^ {1'b1, RABIN_POLY};
         end
      end
      return v[31:0];
   endfunction

   // walk the stream and queue the expected descriptors
   function automatic void build_expected(input dc_t c, input int n);
      logic [31:0] fp;
      logic [31:0] mask;
      int          len;
      int          max_len;
      logic        lst;
      logic        content;
      logic        is_max;
      desc_t       d;
      fp      = '0;
      len     = 0;
      mask    = (32'd1 << c.mask_bits) - 32'd1;
      max_len = (c.max_words == 8'd0) ? 256 : int'(c.max_words);
      for (int i = 0; i < n; i++) begin
         fp      = ref_fold(fp, src_data[i]);
         len     = len + 1;
         lst     = (i == n - 1);
         is_max  = (len >= max_len);
         content = !c.whole && (len >= int'(c.min_words)) && ((fp & mask) == 32'd0);
         if (lst || is_max || content) begin
            d        = '0;
            d.fp     = fp;
            d.length = 16'(len);
            d.last   = lst;
            if (lst) begin
               d.cut = CUT_LAST;
            end else if (is_max) begin
               d.cut = CUT_MAX;
            end else begin
               d.cut = CUT_CONTENT;
            end
            exp_q.push_back(d);
            fp  = '0;
            len = 0;
         end
      end
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s expected %h actual %h", name, exp, act);
      end
   endtask

   // source FIFO, data one cycle after each get
   always @(posedge wb_clk_i) begin
      logic getn_s;
      getn_s = m_src_getn;
      #10;
      if (rst_n && !getn_s) begin
         if (src_idx < src_len) begin
            m_src      = src_data[src_idx];
            m_src_last = (src_idx == src_len - 1);
            src_idx++;
         end else begin
            errors++;
            $display("source FIFO read while empty in %s", cur_test);
         end
      end
      src_rng     = xorshift32(src_rng);
      // random empty gaps, roughly one cycle in four
      m_src_empty = (src_idx >= src_len) || (gap_en && src_rng[1:0] == 2'd0);
   end

   // destination back-pressure bursts
   always @(posedge wb_clk_i) begin
      #10;
      dst_rng = xorshift32(dst_rng);
      if (!full_en) begin
         m_dst_full = 1'b0;
      end else if (m_dst_full) begin
         m_dst_full = (dst_rng[2:0] != 3'd0);
      end else begin
         m_dst_full = (dst_rng[2:0] < 3'd2);
      end
   end

   // compare process on every put
   always @(posedge wb_clk_i) begin
      desc_t e;
      if (rst_n) begin
         if (!m_enable && !m_src_getn) begin
            errors++;
            $display("source read issued while enable was low in %s", cur_test);
         end
         if (!m_endn && (m_dst_putn || !m_dst_last)) begin
            errors++;
            $display("end strobe low without a final put in %s", cur_test);
         end
         if (!m_dst_putn) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("unexpected extra descriptor %h in %s", m_dst, cur_test);
            end else begin
               e = exp_q.pop_front();
               check(cur_test, e, m_dst);
               // last strobe mirrors the descriptor's own flag
               check({cur_test, "_last"}, 64'(e.last), 64'(m_dst_last));
            end
            if (!m_endn) begin
               endn_cnt++;
            end
            if (m_dst_last) begin
               got_last = 1'b1;
            end
            got_cnt++;
         end
      end
   end

   // one stream from start to final descriptor
   task automatic run_stream(input string name, input dc_t c, input int n,
                             input logic gaps, input logic full, input logic hold);
      int cyc;
      for (int i = 0; i < n; i++) begin
         data_rng    = xorshift32(data_rng);
         src_data[i][63:32] = data_rng;
         data_rng    = xorshift32(data_rng);
         src_data[i][31:0]  = data_rng;
      end
      @(posedge wb_clk_i);
      #10;
      cur_test = name;
      exp_q.delete();
      build_expected(c, n);
      got_cnt  = 0;
      endn_cnt = 0;
      got_last = 1'b0;
      gap_en   = gaps;
      full_en  = full;
      dc       = c;
      src_idx  = 0;
      src_len  = n;
      if (hold) begin
         repeat (6) @(posedge wb_clk_i);
         #10;
         m_enable = 1'b0;
         repeat (20) @(posedge wb_clk_i);
         #10;
         m_enable = 1'b1;
      end
      cyc = 0;
      while (!got_last && cyc < TIMEOUT) begin
         @(posedge wb_clk_i);
         cyc++;
      end
      if (!got_last) begin
         errors++;
         $display("%s stalled, no final descriptor within %0d cycles", name, TIMEOUT);
      end
      // let a stray extra put show up
      repeat (4) @(posedge wb_clk_i);
      #10;
      full_en = 1'b0;
      gap_en  = 1'b0;
      if (exp_q.size() != 0) begin
         errors++;
         $display("%s lost %0d descriptors", name, exp_q.size());
      end
      check({name, "_endn"}, 64'd1, 64'(endn_cnt));
   endtask

   initial begin
      dc_t c;
      wb_clk_i    = 1'b0;
      rst_n       = 1'b0;
      m_enable    = 1'b0;
      dc          = '0;
      m_src       = '0;
      m_src_last  = 1'b0;
      m_src_empty = 1'b1;
      m_dst_full  = 1'b0;
      src_len     = 0;
      src_idx     = 0;
      errors      = 0;
      checks      = 0;
      got_cnt     = 0;
      endn_cnt    = 0;
      got_last    = 1'b0;
      gap_en      = 1'b0;
      full_en     = 1'b0;
      data_rng    = 32'd61;
      src_rng     = xorshift32(32'd61);
      dst_rng     = xorshift32(xorshift32(32'd61));
      cur_test    = "reset";

      repeat (10) @(posedge wb_clk_i);
      #10;
      rst_n    = 1'b1;
      m_enable = 1'b1;
      @(posedge wb_clk_i);
      #10;
      check("reset_getn", 64'd1, 64'(m_src_getn));
      check("reset_putn", 64'd1, 64'(m_dst_putn));
      check("reset_endn", 64'd1, 64'(m_endn));
      check("reset_cap", 64'(CAP_RABIN), 64'(m_cap));

      // content cuts
      c           = '0;
      c.mask_bits = 5'd3;
      c.min_words = 8'd2;
      c.max_words = 8'd16;
      run_stream("content", c, 60, 1'b0, 1'b0, 1'b0);

      // forced cuts, 4 x 5 words then 3
      c           = '0;
      c.whole     = 1'b1;
      c.max_words = 8'd5;
      run_stream("forced", c, 23, 1'b0, 1'b0, 1'b0);
      check("forced_count", 64'd5, 64'(got_cnt));

      c           = '0;
      c.mask_bits = 5'd3;
      c.min_words = 8'd2;
      c.max_words = 8'd16;
      run_stream("backpressure", c, 80, 1'b1, 1'b1, 1'b0);
      run_stream("enable_hold", c, 40, 1'b0, 1'b1, 1'b1);

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/rabin_chunker_properties.sv */
//**************************************************
// chunk_decide checks on put, end and queue depth
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module rabin_chunker_properties
   import rabin_pkg::*;
(
   input wire logic                             wb_clk_i,
   input wire logic                             rst_n,
   input wire logic                             m_dst_full,
   input wire logic                             m_dst_putn,
   input wire logic                             m_dst_last,
   input wire logic                             m_endn,
   input wire logic [$clog2(DESCQ_DEPTH+1)-1:0] q_count
);

   // back-pressure holds queued descriptors in place
   full_holds: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
      m_dst_full |=> (q_count >= $past(q_count)))
      else $error("descriptor queue drained while destination FIFO full");

   // queue never overfills
   queue_bound: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
      int'(q_count) <= DESCQ_DEPTH)
      else $error("descriptor queue overflow");

   // end strobe is a single pulse on the final put
   end_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
      (!m_dst_putn && m_dst_last) |=> m_endn)
      else $error("end strobe held past the final put");

endmodule

bind chunk_decide rabin_chunker_properties u_props (
   .wb_clk_i   (wb_clk_i),
   .rst_n      (rst_n),
   .m_dst_full (m_dst_full),
   .m_dst_putn (m_dst_putn),
   .m_dst_last (m_dst_last),
   .m_endn     (m_endn),
   .q_count    (q_count)
);

`default_nettype wire

/* logic/rabin_chunker.sv */
//**************************************************
// rabin_chunker: content-defined chunking engine,
// FIFO in, one descriptor per chunk out
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module rabin_chunker
   import rabin_pkg::*;
(
   input  wire logic              wb_clk_i,
   input  wire logic              rst_n,
   input  wire logic              m_enable,
   input  wire logic [23:0]       dc,
   input  wire logic [WORD_W-1:0] m_src,
   input  wire logic              m_src_last,
   input  wire logic              m_src_empty,
   input  wire logic              m_dst_full,
   output logic                   m_src_getn,
   output logic                   m_dst_putn,
   output logic [WORD_W-1:0]      m_dst,
   output logic                   m_dst_last,
   output logic                   m_endn,
   output logic [7:0]             m_cap
);

   // decoded command word
   dc_t         dc_s;

   // fetch to datapath
   src_word_t   word;
   logic        word_v;

   // accumulator next values
   logic [31:0] fp_next;
   logic [15:0] len_next;
   logic        at_min;
   logic        at_max;

   // decide feedback
   logic        restart;
   logic        room;

   assign dc_s = dc_t'(dc);

   // only the rabinpoly engine is present
   assign m_cap = CAP_RABIN;

   src_fetch u_fetch (
      .wb_clk_i    (wb_clk_i),
      .rst_n       (rst_n),
      .m_enable    (m_enable),
      .m_src_empty (m_src_empty),
      .m_src       (m_src),
      .m_src_last  (m_src_last),
      .room        (room),
      .m_src_getn  (m_src_getn),
      .word        (word),
      .word_v      (word_v)
   );

   // fingerprint and length run side by side
   rabin_fold u_fold (
      .wb_clk_i (wb_clk_i),
      .rst_n    (rst_n),
      .word_v   (word_v),
      .word     (word),
      .restart  (restart),
      .fp_next  (fp_next)
   );

   chunk_length u_len (
      .wb_clk_i (wb_clk_i),
      .rst_n    (rst_n),
      .word_v   (word_v),
      .restart  (restart),
      .dc       (dc_s),
      .len_next (len_next),
      .at_min   (at_min),
      .at_max   (at_max)
   );

   chunk_decide u_decide (
      .wb_clk_i   (wb_clk_i),
      .rst_n      (rst_n),
      .dc         (dc_s),
      .word_v     (word_v),
      .word       (word),
      .fp_next    (fp_next),
      .len_next   (len_next),
      .at_min     (at_min),
      .at_max     (at_max),
      .m_dst_full (m_dst_full),
      .restart    (restart),
      .room       (room),
      .m_dst_putn (m_dst_putn),
      .m_dst      (m_dst),
      .m_dst_last (m_dst_last),
      .m_endn     (m_endn)
   );

endmodule

`default_nettype wire

/* logic/chunk_decide.sv */
//**************************************************
// chunk_decide: cut decision, descriptor queue and
// destination FIFO put and end strobes
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module chunk_decide
   import rabin_pkg::*;
(
   input  wire logic              wb_clk_i,
   input  wire logic              rst_n,
   input  wire dc_t               dc,
   input  wire logic              word_v,
   input  wire src_word_t         word,
   input  wire logic [31:0]       fp_next,
   input  wire logic [15:0]       len_next,
   input  wire logic              at_min,
   input  wire logic              at_max,
   input  wire logic              m_dst_full,
   output logic                   restart,
   output logic                   room,
   output logic                   m_dst_putn,
   output logic [WORD_W-1:0]      m_dst,
   output logic                   m_dst_last,
   output logic                   m_endn
);

   // queue index and occupancy widths
   // depth is a power of two so pointers wrap by themselves
   localparam int PTR_W = (DESCQ_DEPTH > 1) ? $clog2(DESCQ_DEPTH) : 1;
   localparam int CNT_W = $clog2(DESCQ_DEPTH + 1);

   // descriptor storage
   desc_t            q_mem [DESCQ_DEPTH];
   logic [PTR_W-1:0] q_head;
   logic [PTR_W-1:0] q_tail;
   logic [CNT_W-1:0] q_count;

   // current word's descriptor and queue head
   desc_t            desc_new;
   desc_t            desc_head;
   cut_e             cut_sel;

   // low mask_bits ones
   logic [31:0]      fp_mask;
   logic             content_hit;
   logic             push;
   logic             pop;

   assign fp_mask = (32'd1 << dc.mask_bits) - 32'd1;

   // content boundary once past the minimum
   assign content_hit = ~dc.whole & at_min & ((fp_next & fp_mask) == 32'd0);

   // reason by priority: last, max, content
   always_comb begin
      if (word.last) begin
         cut_sel = CUT_LAST;
      end else if (at_max) begin
         cut_sel = CUT_MAX;
      end else begin
         cut_sel = CUT_CONTENT;
      end
   end

   // any cut ends the chunk
   // accumulators clear on this same edge
   assign restart = word_v & (word.last | at_max | content_hit);
   assign push    = restart;

   always_comb begin
      desc_new        = '0;
      desc_new.fp     = fp_next;
      desc_new.length = len_next;
      desc_new.cut    = cut_sel;
      desc_new.last   = word.last;
   end

   // write slot just past the last valid entry
   assign q_tail = q_head + q_count[PTR_W-1:0];

   always_ff @(posedge wb_clk_i) begin
      if (push) begin
         q_mem[q_tail] <= desc_new;
      end
   end

   // head and occupancy
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n) begin
         q_head  <= '0;
         q_count <= '0;
      end else begin
         if (pop) begin
            q_head <= q_head + PTR_W'(1);
         end
         q_count <= q_count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   assign desc_head = q_mem[q_head];

   // put whenever a descriptor waits and the FIFO takes it
   assign pop        = (q_count != '0) & ~m_dst_full;
   assign m_dst_putn = ~pop;
   assign m_dst      = desc_head;
   assign m_dst_last = desc_head.last;
   // end pulse rides on the final put
   assign m_endn     = ~(pop & desc_head.last);

   // fetch only into an empty queue
   assign room = (q_count == '0);

endmodule

`default_nettype wire

/* logic/chunk_length.sv */
//**************************************************
// chunk_length: word count of the open chunk with
// min and max length flags
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module chunk_length
   import rabin_pkg::*;
(
   input  wire logic  wb_clk_i,
   input  wire logic  rst_n,
   input  wire logic  word_v,
   input  wire logic  restart,
   input  wire dc_t   dc,
   output logic [15:0] len_next,
   output logic       at_min,
   output logic       at_max
);

   // words already in the open chunk
   logic [15:0] count;
   // limits widened to the count width
   logic [15:0] min_len;
   logic [15:0] max_len;

   // length once the current word is counted
   assign len_next = count + 16'd1;

   assign min_len = {8'd0, dc.min_words};
   // zero max means 256 words
   assign max_len = (dc.max_words == 8'd0) ? 16'd256 : {8'd0, dc.max_words};

   // content cuts allowed from here on
   assign at_min = (len_next >= min_len);
   // forced cut, >= also covers a max lowered mid chunk
   assign at_max = (len_next >= max_len);

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n) begin
         count <= '0;
      end else if (word_v) begin
         // cut word closes the chunk
         if (restart) begin
            count <= '0;
         end else begin
            count <= len_next;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/rabin_fold.sv */
//**************************************************
// rabin_fold: running chunk fingerprint, folds each
// 64-bit word in modulo the degree-32 generator
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module rabin_fold
   import rabin_pkg::*;
(
   input  wire logic      wb_clk_i,
   input  wire logic      rst_n,
   input  wire logic      word_v,
   input  wire src_word_t word,
   input  wire logic      restart,
   output logic [31:0]    fp_next
);

   // fingerprint of the open chunk
   logic [31:0] fp;

   // (fp_in * x^64 + d) mod (x^32 + RABIN_POLY)
   // msb first, one shift per data bit
   function automatic logic [31:0] fold(
      input logic [31:0]       fp_in,
      input logic [WORD_W-1:0] d
   );
      logic [31:0] r;
      logic        carry;
      r = fp_in;
      for (int i = WORD_W - 1; i >= 0; i--) begin
         // x^32 term about to appear
         carry = r[31];
         r     = {r[30:0], d[i]};
         // subtract the generator, xor in GF(2)
         if (carry) begin
            r = r ^ RABIN_POLY;
         end
      end
      return r;
   endfunction

   // fingerprint including the current word
   // 64 unrolled steps, purely combinational
   assign fp_next = fold(fp, word.data);

   // accumulate on each word
   // a cut clears it so the next word opens a new chunk
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n) begin
         fp <= '0;
      end else if (word_v) begin
         if (restart) begin
            fp <= '0;
         end else begin
            fp <= fp_next;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/src_fetch.sv */
//**************************************************
// src_fetch: source FIFO reader, pops words and
// marks each returned word with word_v
//**************************************************
`timescale 1ns/100ps
`default_nettype none

module src_fetch
   import rabin_pkg::*;
(
   input  wire logic              wb_clk_i,
   input  wire logic              rst_n,
   input  wire logic              m_enable,
   input  wire logic              m_src_empty,
   input  wire logic [WORD_W-1:0] m_src,
   input  wire logic              m_src_last,
   input  wire logic              room,
   output logic                   m_src_getn,
   output src_word_t              word,
   output logic                   word_v
);

   // read issued this cycle
   logic fetch;
   // read outstanding, FIFO data valid now
   logic pend;

   // pop only with enable, an empty descriptor queue
   // and data waiting in the source FIFO
   assign fetch = m_enable & room & ~m_src_empty;

   // active low get strobe
   // stays low across back to back pops
   assign m_src_getn = ~fetch;

   // pipelined read flag
   // FIFO answers one cycle after the get
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n) begin
         pend <= 1'b0;
      end else begin
         pend <= fetch;
      end
   end

   // one pulse per returned word
   assign word_v = pend;

   // returned word goes out with its last flag
   // downstream blocks capture it on the word_v edge
   always_comb begin
      word      = '0;
      word.data = m_src;
      word.last = m_src_last;
   end

endmodule

`default_nettype wire

/* logic/rabin_pkg.sv */
//**************************************************
// rabin chunker shared constants, command word and
// chunk descriptor layouts
//**************************************************
`default_nettype none

package rabin_pkg;

   // low 32 coefficients of the generator
   // x^32 term is implied by the fold
   localparam logic [31:0] RABIN_POLY = 32'hBFE6B8A5;

   // source word and descriptor width
   localparam int WORD_W = 64;

   // capability byte with only the rabinpoly bit (bit 3) set
   localparam logic [7:0] CAP_RABIN = 8'b0000_1000;

   // descriptor queue entries
   // two words can still be in flight when room falls
   localparam int DESCQ_DEPTH = 2;

   // 24-bit command word from the host
   typedef struct packed {
      logic [1:0] rsvd;
      // no content cuts when set
      logic       whole;
      // fp low bits that must be zero
      logic [4:0] mask_bits;
      // shortest chunk that may end on content
      logic [7:0] min_words;
      // forced cut length where 0 reads as 256
      logic [7:0] max_words;
   } dc_t;

   // why a chunk ended
   typedef enum logic [1:0] {
      CUT_CONTENT = 2'd0,
      CUT_MAX     = 2'd1,
      CUT_LAST    = 2'd2
   } cut_e;

   // one 64-bit descriptor per chunk
   typedef struct packed {
      logic [31:0] fp;
      logic [15:0] length;
      logic [12:0] rsvd;
      cut_e        cut;
      logic        last;
   } desc_t;

   // fetched word with its end of stream flag
   typedef struct packed {
      logic              last;
      logic [WORD_W-1:0] data;
   } src_word_t;

endpackage

`default_nettype wire
